// File: flist.f
+incdir+src
+incdir+tb
src/xbar_pkg.sv
src/axil_bus_if.sv
src/master_arbiter.sv
src/write_router.sv
src/read_router.sv
src/axil_xbar_2m4s.sv
tb/tb_axil_xbar.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = tb_axil_xbar
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

localparam int WAIT_WR = 0;   // awready and wready
localparam int WAIT_AR = 1;
localparam int WAIT_R  = 2;

task automatic check_data(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
                          input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_strb(input logic [`STRB_W-1:0] got, input logic [`STRB_W-1:0] exp,
                          input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_addr(input axil_addr_u got, input axil_addr_u exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0d ns: %s is %h, expected %h", $time, what, got.word, exp.word);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("test %s finished with %0d errors", name, errors - errors_before);
endtask

task automatic next_drive();
    @(posedge clk);
    #2;
endtask

function automatic logic master_flag(input bit m, input int kind);
    case (kind)
        WAIT_WR: return m_awready[m] & m_wready[m];
        WAIT_AR: return m_arready[m];
        default: return m_rvalid[m];
    endcase
endfunction

function automatic logic [`DATA_W-1:0] expected_word(input axil_addr_u a);
    return exp_mem[a.fields.region][a.word[5:2]];
endfunction

// samples at the falling edge, the handshake lands on the next rising edge
task automatic wait_master(input bit m, input int kind, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!master_flag(m, kind) && n < TIMEOUT) begin
        if (kind == WAIT_R) begin
            check_flag(m_rvalid[~m], 1'b0, "rvalid of the master without the read");
        end
        n++;
        @(negedge clk);
    end
    if (!master_flag(m, kind)) begin
        $display("timeout: master %0d never saw %s", m, what);
        -> timeout_hit;
    end else if (kind == WAIT_R) begin
        check_flag(m_rvalid[~m], 1'b0, "rvalid of the master without the read");
    end
endtask

task automatic start_write(input bit m, input axil_addr_u a, input logic [`DATA_W-1:0] d,
                           input logic [`STRB_W-1:0] strb);
    m_awaddr[m]  = a.word;
    m_wdata[m]   = d;
    m_wstrb[m]   = strb;
    m_awvalid[m] = 1'b1;
    m_wvalid[m]  = 1'b1;
endtask

task automatic end_write(input bit m);
    axil_addr_u a;
    a = m_awaddr[m];
    @(posedge clk);
    #2;
    exp_mem[a.fields.region][a.word[5:2]] = m_wdata[m];   // slave took it on that edge
    m_awvalid[m] = 1'b0;
    m_wvalid[m]  = 1'b0;
endtask

task automatic issue_read(input bit m, input axil_addr_u a, input logic ready);
    m_araddr[m]  = a.word;
    m_arvalid[m] = 1'b1;
    m_rready[m]  = ready;
    wait_master(m, WAIT_AR, "arready");
    next_drive();
    m_arvalid[m] = 1'b0;
    wait_master(m, WAIT_R, "rvalid");
endtask

task automatic read_word(input bit m, input axil_addr_u a, output logic [`DATA_W-1:0] d);
    issue_read(m, a, 1'b1);
    d = m_rdata[m];
    next_drive();
    m_rready[m] = 1'b0;
endtask

task automatic idle_after_reset();
    int e;
    e = errors;
    @(negedge clk);
    for (int m = 0; m < 2; m++) begin
        check_flag(m_awready[1'(m)], 1'b0, $sformatf("master %0d awready", m));
        check_flag(m_wready[1'(m)], 1'b0, $sformatf("master %0d wready", m));
        check_flag(m_arready[1'(m)], 1'b0, $sformatf("master %0d arready", m));
        check_flag(m_rvalid[1'(m)], 1'b0, $sformatf("master %0d rvalid", m));
    end
    check_flag(|s_awvalid, 1'b0, "any slave awvalid");
    check_flag(|s_wvalid, 1'b0, "any slave wvalid");
    check_flag(|s_arvalid, 1'b0, "any slave arvalid");
    report_test("idle after reset", e);
endtask

task automatic region_routing();
    axil_addr_u         a;
    logic [`DATA_W-1:0] d;
    logic [`DATA_W-1:0] got;
    logic [31:0]        rnd;
    int                 e;
    e = errors;
    next_drive();
    for (int r = 0; r < `SLAVE_COUNT; r++) begin
        rnd = $random(seed);
        d   = $random(seed);
        a.fields.region = `REGION_W'(r);
        a.fields.offset = `OFFSET_W'({rnd[3:0], 2'b00});   // word aligned, one of 16
        start_write(1'b0, a, d, rnd[7:4]);
        wait_master(1'b0, WAIT_WR, "write ready");
        for (int j = 0; j < `SLAVE_COUNT; j++) begin
            check_flag(s_awvalid[`REGION_W'(j)], j == r, $sformatf("slave %0d awvalid", j));
            if (j != r) begin
                check_addr(s_awaddr[`REGION_W'(j)], '0, $sformatf("slave %0d awaddr", j));
            end
            check_data(s_wdata[`REGION_W'(j)], d, $sformatf("slave %0d wdata", j));
            check_strb(s_wstrb[`REGION_W'(j)], rnd[7:4], $sformatf("slave %0d wstrb", j));
        end
        check_addr(s_awaddr[`REGION_W'(r)], a, "selected slave awaddr");
        end_write(1'b0);
        read_word(1'b0, a, got);
        check_data(got, expected_word(a), $sformatf("region %0d read data", r));
    end
    report_test("region routing", e);
endtask

task automatic write_priority();
    axil_addr_u         a0;
    axil_addr_u         a1;
    logic [`DATA_W-1:0] got;
    int                 e;
    e = errors;
    a0.fields.region = `REGION_W'(1);
    a0.fields.offset = `OFFSET_W'('h14);
    a1.fields.region = `REGION_W'(2);
    a1.fields.offset = `OFFSET_W'('h18);
    next_drive();
    start_write(1'b0, a0, $random(seed), '1);
    start_write(1'b1, a1, $random(seed), '1);   // same cycle as master 0
    @(negedge clk);   // grants are combinational
    check_flag(m_awready[1'b0], 1'b1, "master 0 awready");
    check_flag(m_wready[1'b0], 1'b1, "master 0 wready");
    check_flag(m_awready[1'b1], 1'b0, "master 1 awready while master 0 writes");
    check_flag(m_wready[1'b1], 1'b0, "master 1 wready while master 0 writes");
    end_write(1'b0);
    wait_master(1'b1, WAIT_WR, "write ready");
    end_write(1'b1);
    read_word(1'b0, a0, got);
    check_data(got, expected_word(a0), "master 0 word");
    read_word(1'b0, a1, got);
    check_data(got, expected_word(a1), "master 1 word");
    report_test("write priority", e);
endtask

task automatic read_ownership();
    axil_addr_u         a;
    logic [`DATA_W-1:0] got;
    int                 e;
    e = errors;
    a.fields.region = `REGION_W'(2);
    a.fields.offset = `OFFSET_W'('h18);
    next_drive();
    read_word(1'b1, a, got);   // master 0 rvalid checked while waiting
    check_data(got, expected_word(a), "master 1 read data");
    @(negedge clk);
    check_flag(m_rvalid[1'b0], 1'b0, "master 0 rvalid after the read");
    check_flag(m_rvalid[1'b1], 1'b0, "master 1 rvalid after the read");
    report_test("read ownership", e);
endtask

task automatic read_backpressure();
    axil_addr_u         a;
    logic [`DATA_W-1:0] held;
    int                 e;
    e = errors;
    a.fields.region = `REGION_W'(1);
    a.fields.offset = `OFFSET_W'('h14);
    next_drive();
    issue_read(1'b0, a, 1'b0);
    held = m_rdata[1'b0];
    check_data(held, expected_word(a), "read data under back-pressure");
    repeat (4) begin
        @(negedge clk);
        check_flag(m_rvalid[1'b0], 1'b1, "rvalid held by back-pressure");
        check_data(m_rdata[1'b0], held, "rdata held by back-pressure");
    end
    next_drive();
    m_rready[1'b0] = 1'b1;
    @(negedge clk);
    check_flag(m_rvalid[1'b0], 1'b1, "rvalid before the r handshake");
    next_drive();
    m_rready[1'b0] = 1'b0;
    @(negedge clk);
    check_flag(m_rvalid[1'b0], 1'b0, "rvalid after the r handshake");
    report_test("read back-pressure", e);
endtask

`endif

// File: tb/tb_axil_xbar.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_consts.svh"

module tb_axil_xbar import xbar_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT    = 50;   // cycles allowed per wait
    localparam int MEM_WORDS  = 16;

    logic   clk;
    logic   rst_n;
    integer seed;
    int     checks;
    int     errors;
    int     tests;
    event   timeout_hit;

    logic [`ADDR_W-1:0] m0_awaddr, m1_awaddr, m0_araddr, m1_araddr;
    logic [`DATA_W-1:0] m0_wdata, m1_wdata, m0_rdata, m1_rdata;
    logic [`STRB_W-1:0] m0_wstrb, m1_wstrb;
    logic m0_awvalid, m0_wvalid, m0_arvalid, m0_rready;
    logic m1_awvalid, m1_wvalid, m1_arvalid, m1_rready;
    logic m0_awready, m0_wready, m0_arready, m0_rvalid;
    logic m1_awready, m1_wready, m1_arready, m1_rvalid;

    logic [`ADDR_W-1:0] s0_awaddr, s1_awaddr, s2_awaddr, s3_awaddr;
    logic [`ADDR_W-1:0] s0_araddr, s1_araddr, s2_araddr, s3_araddr;
    logic [`DATA_W-1:0] s0_wdata, s1_wdata, s2_wdata, s3_wdata;
    logic [`DATA_W-1:0] s0_rdata, s1_rdata, s2_rdata, s3_rdata;
    logic [`STRB_W-1:0] s0_wstrb, s1_wstrb, s2_wstrb, s3_wstrb;
    logic s0_awvalid, s1_awvalid, s2_awvalid, s3_awvalid;
    logic s0_awready, s1_awready, s2_awready, s3_awready;
    logic s0_wvalid, s1_wvalid, s2_wvalid, s3_wvalid;
    logic s0_wready, s1_wready, s2_wready, s3_wready;
    logic s0_arvalid, s1_arvalid, s2_arvalid, s3_arvalid;
    logic s0_arready, s1_arready, s2_arready, s3_arready;
    logic s0_rvalid, s1_rvalid, s2_rvalid, s3_rvalid;
    logic s0_rready, s1_rready, s2_rready, s3_rready;

    // master side, index 0 is master 0
    logic [1:0][`ADDR_W-1:0] m_awaddr, m_araddr;
    logic [1:0][`DATA_W-1:0] m_wdata;
    logic [1:0][`STRB_W-1:0] m_wstrb;
    logic [1:0]              m_awvalid, m_wvalid, m_arvalid, m_rready;

    assign {m1_awaddr, m0_awaddr}   = m_awaddr;
    assign {m1_araddr, m0_araddr}   = m_araddr;
    assign {m1_wdata, m0_wdata}     = m_wdata;
    assign {m1_wstrb, m0_wstrb}     = m_wstrb;
    assign {m1_awvalid, m0_awvalid} = m_awvalid;
    assign {m1_wvalid, m0_wvalid}   = m_wvalid;
    assign {m1_arvalid, m0_arvalid} = m_arvalid;
    assign {m1_rready, m0_rready}   = m_rready;

    wire [1:0]              m_awready = {m1_awready, m0_awready};
    wire [1:0]              m_wready  = {m1_wready, m0_wready};
    wire [1:0]              m_arready = {m1_arready, m0_arready};
    wire [1:0]              m_rvalid  = {m1_rvalid, m0_rvalid};
    wire [1:0][`DATA_W-1:0] m_rdata   = {m1_rdata, m0_rdata};

    // slave side, index is the region
    wire [`SLAVE_COUNT-1:0][`ADDR_W-1:0] s_awaddr = {s3_awaddr, s2_awaddr, s1_awaddr, s0_awaddr};
    wire [`SLAVE_COUNT-1:0][`ADDR_W-1:0] s_araddr = {s3_araddr, s2_araddr, s1_araddr, s0_araddr};
    wire [`SLAVE_COUNT-1:0][`DATA_W-1:0] s_wdata  = {s3_wdata, s2_wdata, s1_wdata, s0_wdata};
    wire [`SLAVE_COUNT-1:0][`STRB_W-1:0] s_wstrb  = {s3_wstrb, s2_wstrb, s1_wstrb, s0_wstrb};
    wire [`SLAVE_COUNT-1:0] s_awvalid = {s3_awvalid, s2_awvalid, s1_awvalid, s0_awvalid};
    wire [`SLAVE_COUNT-1:0] s_wvalid  = {s3_wvalid, s2_wvalid, s1_wvalid, s0_wvalid};
    wire [`SLAVE_COUNT-1:0] s_arvalid = {s3_arvalid, s2_arvalid, s1_arvalid, s0_arvalid};
    wire [`SLAVE_COUNT-1:0] s_rready  = {s3_rready, s2_rready, s1_rready, s0_rready};
    wire [`SLAVE_COUNT-1:0] s_wr_ok   = s_awvalid & s_wvalid;   // aw and w taken together

    logic [`SLAVE_COUNT-1:0]              s_rvalid;
    logic [`SLAVE_COUNT-1:0][`DATA_W-1:0] s_rdata;
    logic [`DATA_W-1:0]                   exp_mem [`SLAVE_COUNT][MEM_WORDS];

    assign {s3_awready, s2_awready, s1_awready, s0_awready} = s_wr_ok;
    assign {s3_wready, s2_wready, s1_wready, s0_wready}     = s_wr_ok;
    assign {s3_arready, s2_arready, s1_arready, s0_arready} = {`SLAVE_COUNT{1'b1}};
    assign {s3_rdata, s2_rdata, s1_rdata, s0_rdata}         = s_rdata;
    assign {s3_rvalid, s2_rvalid, s1_rvalid, s0_rvalid}     = s_rvalid;

    axil_xbar_2m4s u_axil_xbar_2m4s (.*);

    // slave responders, a 16 word store each
    for (genvar g = 0; g < `SLAVE_COUNT; g++) begin : g_slave
        logic [`DATA_W-1:0] mem [MEM_WORDS];   // indexed by address bits 5:2
        logic               rvalid_q;
        logic [`DATA_W-1:0] rdata_q;

        assign s_rvalid[g] = rvalid_q;
        assign s_rdata[g]  = rdata_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rvalid_q <= 1'b0;
                rdata_q  <= '0;
            end else begin
                if (s_wr_ok[g]) begin
                    mem[s_awaddr[g][5:2]] <= s_wdata[g];
                end
                if (s_arvalid[g]) begin   // arready tied high
                    rvalid_q <= 1'b1;
                    rdata_q  <= mem[s_araddr[g][5:2]];
                end else if (rvalid_q & s_rready[g]) begin
                    rvalid_q <= 1'b0;
                end
            end
        end
    end

    `include "tb_axil_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        @(timeout_hit);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        seed      = 32'hd5bf;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        m_awaddr  = '0;
        m_araddr  = '0;
        m_wdata   = '0;
        m_wstrb   = '0;
        m_awvalid = '0;
        m_wvalid  = '0;
        m_arvalid = '0;
        m_rready  = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle_after_reset();
        region_routing();
        write_priority();
        read_ownership();
        read_backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/axil_xbar_2m4s.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_consts.svh"

module axil_xbar_2m4s (
    input  logic                clk,
    input  logic                rst_n,
    // master 0
    input  logic [`ADDR_W-1:0]  m0_awaddr,
    input  logic [`DATA_W-1:0]  m0_wdata,
    input  logic [`STRB_W-1:0]  m0_wstrb,
    input  logic                m0_awvalid,
    input  logic                m0_wvalid,
    input  logic [`ADDR_W-1:0]  m0_araddr,
    input  logic                m0_arvalid,
    input  logic                m0_rready,
    output logic                m0_awready,
    output logic                m0_wready,
    output logic                m0_arready,
    output logic [`DATA_W-1:0]  m0_rdata,
    output logic                m0_rvalid,
    // master 1
    input  logic [`ADDR_W-1:0]  m1_awaddr,
    input  logic [`DATA_W-1:0]  m1_wdata,
    input  logic [`STRB_W-1:0]  m1_wstrb,
    input  logic                m1_awvalid,
    input  logic                m1_wvalid,
    input  logic [`ADDR_W-1:0]  m1_araddr,
    input  logic                m1_arvalid,
    input  logic                m1_rready,
    output logic                m1_awready,
    output logic                m1_wready,
    output logic                m1_arready,
    output logic [`DATA_W-1:0]  m1_rdata,
    output logic                m1_rvalid,
    // slaves 0 to 3
    output logic [`ADDR_W-1:0]  s0_awaddr, s1_awaddr, s2_awaddr, s3_awaddr,
    output logic                s0_awvalid, s1_awvalid, s2_awvalid, s3_awvalid,
    input  logic                s0_awready, s1_awready, s2_awready, s3_awready,
    output logic [`DATA_W-1:0]  s0_wdata, s1_wdata, s2_wdata, s3_wdata,
    output logic [`STRB_W-1:0]  s0_wstrb, s1_wstrb, s2_wstrb, s3_wstrb,
    output logic                s0_wvalid, s1_wvalid, s2_wvalid, s3_wvalid,
    input  logic                s0_wready, s1_wready, s2_wready, s3_wready,
    output logic [`ADDR_W-1:0]  s0_araddr, s1_araddr, s2_araddr, s3_araddr,
    output logic                s0_arvalid, s1_arvalid, s2_arvalid, s3_arvalid,
    input  logic                s0_arready, s1_arready, s2_arready, s3_arready,
    input  logic [`DATA_W-1:0]  s0_rdata, s1_rdata, s2_rdata, s3_rdata,
    input  logic                s0_rvalid, s1_rvalid, s2_rvalid, s3_rvalid,
    output logic                s0_rready, s1_rready, s2_rready, s3_rready
);

    logic [`SLAVE_COUNT-1:0][`ADDR_W-1:0] s_awaddr;
    logic [`SLAVE_COUNT-1:0]              s_awvalid;
    logic [`SLAVE_COUNT-1:0][`DATA_W-1:0] s_wdata;
    logic [`SLAVE_COUNT-1:0][`STRB_W-1:0] s_wstrb;
    logic [`SLAVE_COUNT-1:0]              s_wvalid;
    logic [`SLAVE_COUNT-1:0][`ADDR_W-1:0] s_araddr;
    logic [`SLAVE_COUNT-1:0]              s_arvalid;
    logic [`SLAVE_COUNT-1:0]              s_rready;

    axil_wr_if wr_bus ();
    axil_rd_if rd_bus ();

    // unpack per slave arrays, index 0 is the low slice
    assign {s3_awaddr, s2_awaddr, s1_awaddr, s0_awaddr}     = s_awaddr;
    assign {s3_awvalid, s2_awvalid, s1_awvalid, s0_awvalid} = s_awvalid;
    assign {s3_wdata, s2_wdata, s1_wdata, s0_wdata}         = s_wdata;
    assign {s3_wstrb, s2_wstrb, s1_wstrb, s0_wstrb}         = s_wstrb;
    assign {s3_wvalid, s2_wvalid, s1_wvalid, s0_wvalid}     = s_wvalid;
    assign {s3_araddr, s2_araddr, s1_araddr, s0_araddr}     = s_araddr;
    assign {s3_arvalid, s2_arvalid, s1_arvalid, s0_arvalid} = s_arvalid;
    assign {s3_rready, s2_rready, s1_rready, s0_rready}     = s_rready;

    master_arbiter u_master_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .m0_awaddr  (m0_awaddr),
        .m0_wdata   (m0_wdata),
        .m0_wstrb   (m0_wstrb),
        .m0_awvalid (m0_awvalid),
        .m0_wvalid  (m0_wvalid),
        .m0_araddr  (m0_araddr),
        .m0_arvalid (m0_arvalid),
        .m0_rready  (m0_rready),
        .m0_awready (m0_awready),
        .m0_wready  (m0_wready),
        .m0_arready (m0_arready),
        .m0_rdata   (m0_rdata),
        .m0_rvalid  (m0_rvalid),
        .m1_awaddr  (m1_awaddr),
        .m1_wdata   (m1_wdata),
        .m1_wstrb   (m1_wstrb),
        .m1_awvalid (m1_awvalid),
        .m1_wvalid  (m1_wvalid),
        .m1_araddr  (m1_araddr),
        .m1_arvalid (m1_arvalid),
        .m1_rready  (m1_rready),
        .m1_awready (m1_awready),
        .m1_wready  (m1_wready),
        .m1_arready (m1_arready),
        .m1_rdata   (m1_rdata),
        .m1_rvalid  (m1_rvalid),
        .wr_bus     (wr_bus.arb),
        .rd_bus     (rd_bus.arb)
    );

    write_router u_write_router (
        .wr_bus    (wr_bus.router),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_awready ({s3_awready, s2_awready, s1_awready, s0_awready}),
        .s_wready  ({s3_wready, s2_wready, s1_wready, s0_wready})
    );

    read_router u_read_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_bus    (rd_bus.router),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_rready  (s_rready),
        .s_arready ({s3_arready, s2_arready, s1_arready, s0_arready}),
        .s_rdata   ({s3_rdata, s2_rdata, s1_rdata, s0_rdata}),
        .s_rvalid  ({s3_rvalid, s2_rvalid, s1_rvalid, s0_rvalid})
    );

endmodule

`default_nettype wire

// File: src/read_router.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_consts.svh"

module read_router import xbar_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst_n,
    axil_rd_if.router                            rd_bus,
    output logic [`SLAVE_COUNT-1:0][`ADDR_W-1:0] s_araddr,
    output logic [`SLAVE_COUNT-1:0]              s_arvalid,
    output logic [`SLAVE_COUNT-1:0]              s_rready,
    input  logic [`SLAVE_COUNT-1:0]              s_arready,
    input  logic [`SLAVE_COUNT-1:0][`DATA_W-1:0] s_rdata,
    input  logic [`SLAVE_COUNT-1:0]              s_rvalid
);

    axil_addr_u              ar_addr;
    logic [`REGION_W-1:0]    rd_region_q;   // slave that owes read data
    logic [`SLAVE_COUNT-1:0] ar_sel;
    logic [`SLAVE_COUNT-1:0] r_sel;

    assign ar_addr = rd_bus.araddr;

    always_comb begin
        for (int i = 0; i < `SLAVE_COUNT; i++) begin
            ar_sel[i]    = (ar_addr.fields.region == `REGION_W'(i));
            r_sel[i]     = (rd_region_q == `REGION_W'(i));
            s_araddr[i]  = ar_sel[i] ? ar_addr.word : '0;
            s_arvalid[i] = ar_sel[i] & rd_bus.arvalid;
            s_rready[i]  = r_sel[i] & rd_bus.rready;   // only the owed slave is released
        end
    end

    assign rd_bus.arready = |(ar_sel & s_arready);
    assign rd_bus.rdata   = s_rdata[rd_region_q];
    assign rd_bus.rvalid  = |(r_sel & s_rvalid);

    // remember where the accepted read went
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_region_q <= '0;
        end else if (rd_bus.arvalid & rd_bus.arready) begin
            rd_region_q <= ar_addr.fields.region;
        end
    end

endmodule

`default_nettype wire

// File: src/write_router.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_consts.svh"

module write_router import xbar_pkg::*; (
    axil_wr_if.router                           wr_bus,
    output logic [`SLAVE_COUNT-1:0][`ADDR_W-1:0] s_awaddr,
    output logic [`SLAVE_COUNT-1:0]              s_awvalid,
    output logic [`SLAVE_COUNT-1:0][`DATA_W-1:0] s_wdata,
    output logic [`SLAVE_COUNT-1:0][`STRB_W-1:0] s_wstrb,
    output logic [`SLAVE_COUNT-1:0]              s_wvalid,
    input  logic [`SLAVE_COUNT-1:0]              s_awready,
    input  logic [`SLAVE_COUNT-1:0]              s_wready
);

    axil_addr_u              aw_addr;
    logic [`SLAVE_COUNT-1:0] wr_sel;   // one hot slave select

    assign aw_addr = wr_bus.awaddr;

    always_comb begin
        for (int i = 0; i < `SLAVE_COUNT; i++) begin
            wr_sel[i]    = (aw_addr.fields.region == `REGION_W'(i));
            s_awaddr[i]  = wr_sel[i] ? aw_addr.word : '0;   // unselected slaves see zero
            s_awvalid[i] = wr_sel[i] & wr_bus.awvalid;
            s_wvalid[i]  = wr_sel[i] & wr_bus.wvalid;
            s_wdata[i]   = wr_bus.wdata;   // data and strobes go everywhere
            s_wstrb[i]   = wr_bus.wstrb;
        end
    end

    assign wr_bus.awready = |(wr_sel & s_awready);
    assign wr_bus.wready  = |(wr_sel & s_wready);

endmodule

`default_nettype wire

// File: src/master_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_consts.svh"

module master_arbiter import xbar_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`ADDR_W-1:0] m0_awaddr,
    input  logic [`DATA_W-1:0] m0_wdata,
    input  logic [`STRB_W-1:0] m0_wstrb,
    input  logic               m0_awvalid,
    input  logic               m0_wvalid,
    input  logic [`ADDR_W-1:0] m0_araddr,
    input  logic               m0_arvalid,
    input  logic               m0_rready,
    output logic               m0_awready,
    output logic               m0_wready,
    output logic               m0_arready,
    output logic [`DATA_W-1:0] m0_rdata,
    output logic               m0_rvalid,
    input  logic [`ADDR_W-1:0] m1_awaddr,
    input  logic [`DATA_W-1:0] m1_wdata,
    input  logic [`STRB_W-1:0] m1_wstrb,
    input  logic               m1_awvalid,
    input  logic               m1_wvalid,
    input  logic [`ADDR_W-1:0] m1_araddr,
    input  logic               m1_arvalid,
    input  logic               m1_rready,
    output logic               m1_awready,
    output logic               m1_wready,
    output logic               m1_arready,
    output logic [`DATA_W-1:0] m1_rdata,
    output logic               m1_rvalid,
    axil_wr_if.arb             wr_bus,
    axil_rd_if.arb             rd_bus
);

    axil_addr_u aw_pick;   // address of the granted writer
    axil_addr_u ar_pick;   // address of the granted reader
    logic       m0_wr_gnt;
    logic       m1_wr_gnt;
    logic       m0_ar_gnt;
    logic       m1_ar_gnt;
    logic       m0_rd_own;   // m0 waits for read data
    logic       m1_rd_own;

    // a write needs aw and w together, m0 wins a tie
    assign m0_wr_gnt = m0_awvalid & m0_wvalid;
    assign m1_wr_gnt = m1_awvalid & m1_wvalid & ~m0_wr_gnt;
    assign m0_ar_gnt = m0_arvalid;
    assign m1_ar_gnt = m1_arvalid & ~m0_arvalid;

    assign aw_pick = m0_wr_gnt ? m0_awaddr : m1_awaddr;
    assign ar_pick = m0_ar_gnt ? m0_araddr : m1_araddr;

    assign wr_bus.awaddr  = aw_pick;
    assign wr_bus.wdata   = m0_wr_gnt ? m0_wdata : m1_wdata;
    assign wr_bus.wstrb   = m0_wr_gnt ? m0_wstrb : m1_wstrb;
    assign wr_bus.awvalid = m0_wr_gnt | m1_wr_gnt;   // grant already implies valid
    assign wr_bus.wvalid  = m0_wr_gnt | m1_wr_gnt;

    assign rd_bus.araddr  = ar_pick;
    assign rd_bus.arvalid = m0_ar_gnt | m1_ar_gnt;
    assign rd_bus.rready  = (m0_rd_own & m0_rready) | (m1_rd_own & m1_rready);

    assign m0_awready = m0_wr_gnt & wr_bus.awready;
    assign m0_wready  = m0_wr_gnt & wr_bus.wready;
    assign m0_arready = m0_ar_gnt & rd_bus.arready;
    assign m0_rdata   = rd_bus.rdata;   // both masters see the data
    assign m0_rvalid  = m0_rd_own & rd_bus.rvalid;

    assign m1_awready = m1_wr_gnt & wr_bus.awready;
    assign m1_wready  = m1_wr_gnt & wr_bus.wready;
    assign m1_arready = m1_ar_gnt & rd_bus.arready;
    assign m1_rdata   = rd_bus.rdata;
    assign m1_rvalid  = m1_rd_own & rd_bus.rvalid;

    // read channel owner, set on ar handshake and cleared on r handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m0_rd_own <= 1'b0;
            m1_rd_own <= 1'b0;
        end else begin
            if (m0_arvalid & m0_arready) begin
                m0_rd_own <= 1'b1;
            end else if (m0_rvalid & m0_rready) begin
                m0_rd_own <= 1'b0;
            end
            if (m1_arvalid & m1_arready) begin
                m1_rd_own <= 1'b1;
            end else if (m1_rvalid & m1_rready) begin
                m1_rd_own <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/axil_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_consts.svh"

// shared write bus between arbiter and write router
interface axil_wr_if import xbar_pkg::*; ();
    axil_addr_u          awaddr;
    logic [`DATA_W-1:0]  wdata;
    logic [`STRB_W-1:0]  wstrb;
    logic                awvalid;
    logic                wvalid;
    logic                awready;
    logic                wready;

    modport arb (
        output awaddr, wdata, wstrb, awvalid, wvalid,
        input  awready, wready
    );
    modport router (
        input  awaddr, wdata, wstrb, awvalid, wvalid,
        output awready, wready
    );
endinterface

// shared read bus between arbiter and read router
interface axil_rd_if import xbar_pkg::*; ();
    axil_addr_u          araddr;
    logic                arvalid;
    logic                arready;
    logic [`DATA_W-1:0]  rdata;
    logic                rvalid;
    logic                rready;

    modport arb (
        output araddr, arvalid, rready,
        input  arready, rdata, rvalid
    );
    modport router (
        input  araddr, arvalid, rready,
        output arready, rdata, rvalid
    );
endinterface

`default_nettype wire

// File: src/xbar_pkg.sv
`default_nettype none

`include "xbar_consts.svh"

package xbar_pkg;

    // one address word, seen flat or as slave index plus offset
    typedef union packed {
        logic [`ADDR_W-1:0] word;
        struct packed {
            logic [`REGION_W-1:0] region;   // slave index
            logic [`OFFSET_W-1:0] offset;   // address inside the slave
        } fields;
    } axil_addr_u;

endpackage

`default_nettype wire

// File: src/xbar_consts.svh
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

`define ADDR_W      32
`define DATA_W      32
`define STRB_W      4
`define SLAVE_COUNT 4

// top bits of the address pick the slave
`define REGION_W    2
`define OFFSET_W    30

`endif
